/* hdl/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

  // R-type view of the instruction word
  typedef struct packed {
    logic [5:0] opcode;  // Always 0 for R-type
    logic [4:0] rs;      // First source register
    logic [4:0] rt;      // Second source register
    logic [4:0] rd;      // Destination register
    logic [4:0] shamt;   // Fixed shift amount
    logic [5:0] funct;   // Selects the ALU function
  } r_fields_t;

  // I-type view of the same word
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;     // Source register
    logic [4:0]  rt;     // Destination for immediates, second source for branches
    logic [15:0] imm;    // Immediate or branch offset
  } i_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_u;

  // Opcodes
  localparam logic [5:0] OPC_RTYPE = 6'h00;
  localparam logic [5:0] OPC_BEQ   = 6'h04;
  localparam logic [5:0] OPC_BNE   = 6'h05;
  localparam logic [5:0] OPC_ADDI  = 6'h08;
  localparam logic [5:0] OPC_ADDIU = 6'h09;
  localparam logic [5:0] OPC_SLTI  = 6'h0a;
  localparam logic [5:0] OPC_SLTIU = 6'h0b;
  localparam logic [5:0] OPC_ANDI  = 6'h0c;
  localparam logic [5:0] OPC_ORI   = 6'h0d;
  localparam logic [5:0] OPC_XORI  = 6'h0e;
  localparam logic [5:0] OPC_LUI   = 6'h0f;

  // R-type function codes
  localparam logic [5:0] FUNC_SLL  = 6'h00;
  localparam logic [5:0] FUNC_SRL  = 6'h02;
  localparam logic [5:0] FUNC_SRA  = 6'h03;
  localparam logic [5:0] FUNC_SLLV = 6'h04;
  localparam logic [5:0] FUNC_SRLV = 6'h06;
  localparam logic [5:0] FUNC_SRAV = 6'h07;
  localparam logic [5:0] FUNC_ADD  = 6'h20;
  localparam logic [5:0] FUNC_ADDU = 6'h21;
  localparam logic [5:0] FUNC_SUB  = 6'h22;
  localparam logic [5:0] FUNC_SUBU = 6'h23;
  localparam logic [5:0] FUNC_AND  = 6'h24;
  localparam logic [5:0] FUNC_OR   = 6'h25;
  localparam logic [5:0] FUNC_XOR  = 6'h26;
  localparam logic [5:0] FUNC_NOR  = 6'h27;
  localparam logic [5:0] FUNC_SLT  = 6'h2a;
  localparam logic [5:0] FUNC_SLTU = 6'h2b;

endpackage

`default_nettype wire

/* hdl/alu_pkg.sv */
`default_nettype none

package alu_pkg;

  // Class handed from main control to ALU control
  typedef enum logic [2:0] {
    ALU_OP_ADD   = 3'd0,  // Adds, loads, unknown opcodes
    ALU_OP_SUB   = 3'd1,  // BEQ and BNE compare
    ALU_OP_RTYPE = 3'd2,  // Decode funct
    ALU_OP_IMM   = 3'd3,  // Decode I-type opcode
    ALU_OP_LUI   = 3'd4
  } alu_op_e;

  // Operation the ALU performs
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_NOR  = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SLT  = 4'd6,   // Signed compare
    ALU_SLTU = 4'd7,   // Unsigned compare
    ALU_SLL  = 4'd8,
    ALU_SRL  = 4'd9,
    ALU_SRA  = 4'd10,  // Sign-filling shift
    ALU_LUI  = 4'd11   // Immediate to upper half
  } alu_ctrl_e;

endpackage

`default_nettype wire

/* hdl/ex_op_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ex_op_if import alu_pkg::*;;

  logic        valid;      // Operation held
  logic        ready;      // Sink can take it
  alu_op_e     alu_op;     // Main-control class
  logic [5:0]  func_code;  // R-type funct
  logic [5:0]  i_opcode;   // I-type opcode
  logic [31:0] opa;        // Shift amount for shifts
  logic [31:0] opb;        // Shifted value for shifts
  logic [4:0]  dest;       // Destination register

  modport source (
    output valid, alu_op, func_code, i_opcode, opa, opb, dest,
    input  ready
  );

  modport sink (
    input  valid, alu_op, func_code, i_opcode, opa, opb, dest,
    output ready
  );

endinterface

`default_nettype wire

/* hdl/main_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module main_decoder import mips_isa_pkg::*, alu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid,
  output logic        instr_ready,
  input  instr_u      instr,
  input  logic [31:0] rs_val,
  input  logic [31:0] rt_val,
  ex_op_if.source     out_op
);

  alu_op_e     alu_op_d;  // Next class
  logic [31:0] opa_d;
  logic [31:0] opb_d;
  logic [4:0]  dest_d;
  logic [31:0] imm_sext;  // Arithmetic and compare immediates
  logic [31:0] imm_zext;  // Logical immediates and LUI
  logic        fixed_shift;
  logic        take;

  assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
  assign imm_zext = {16'h0000, instr.i.imm};
  assign fixed_shift = (instr.r.funct == FUNC_SLL) || (instr.r.funct == FUNC_SRL) ||
                       (instr.r.funct == FUNC_SRA);

  always_comb begin
    alu_op_d = ALU_OP_ADD;  // Unknown opcodes add
    opa_d    = rs_val;
    opb_d    = imm_sext;
    dest_d   = instr.i.rt;
    case (instr.i.opcode)
      OPC_RTYPE: begin
        alu_op_d = ALU_OP_RTYPE;
        opb_d    = rt_val;
        dest_d   = instr.r.rd;
        if (fixed_shift) begin
          opa_d = {27'd0, instr.r.shamt};  // Shift count from the word itself
        end
      end
      OPC_ADDI, OPC_ADDIU: alu_op_d = ALU_OP_ADD;
      OPC_ANDI, OPC_ORI, OPC_XORI: begin
        alu_op_d = ALU_OP_IMM;
        opb_d    = imm_zext;
      end
      OPC_SLTI, OPC_SLTIU: alu_op_d = ALU_OP_IMM;  // SLTIU still sign-extends
      OPC_LUI: begin
        alu_op_d = ALU_OP_LUI;
        opb_d    = imm_zext;
      end
      OPC_BEQ, OPC_BNE: begin
        alu_op_d = ALU_OP_SUB;  // Difference for the compare
        opb_d    = rt_val;
        dest_d   = 5'd0;        // No writeback
      end
      default: ;
    endcase
  end

  assign instr_ready = !out_op.valid || out_op.ready;  // Empty or draining
  assign take        = instr_valid && instr_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_op.valid <= 1'b0;
    end else if (instr_ready) begin
      out_op.valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_op.alu_op    <= alu_op_d;
      out_op.func_code <= instr.r.funct;
      out_op.i_opcode  <= instr.i.opcode;
      out_op.opa       <= opa_d;
      out_op.opb       <= opb_d;
      out_op.dest      <= dest_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/op_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module op_fifo import alu_pkg::*; #(
  parameter int DEPTH = 4  // Power of two, at least 2
) (
  input  logic    clk,
  input  logic    rst_n,
  ex_op_if.sink   in_op,
  ex_op_if.source out_op
);

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

  alu_op_e     alu_op_mem [DEPTH];
  logic [5:0]  func_mem   [DEPTH];
  logic [5:0]  iop_mem    [DEPTH];
  logic [31:0] opa_mem    [DEPTH];
  logic [31:0] opb_mem    [DEPTH];
  logic [4:0]  dest_mem   [DEPTH];

  logic [AW-1:0] wr_ptr;  // Wraps with the power-of-two depth
  logic [AW-1:0] rd_ptr;  // Head entry
  logic [AW:0]   count;   // Entries held
  logic          push;
  logic          pop;

  assign in_op.ready  = (count != FULL_CNT);
  assign out_op.valid = (count != '0);
  assign push = in_op.valid && in_op.ready;
  assign pop  = out_op.valid && out_op.ready;

  // Head entry straight from storage
  assign out_op.alu_op    = alu_op_mem[rd_ptr];
  assign out_op.func_code = func_mem[rd_ptr];
  assign out_op.i_opcode  = iop_mem[rd_ptr];
  assign out_op.opa       = opa_mem[rd_ptr];
  assign out_op.opb       = opb_mem[rd_ptr];
  assign out_op.dest      = dest_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      alu_op_mem[wr_ptr] <= in_op.alu_op;
      func_mem[wr_ptr]   <= in_op.func_code;
      iop_mem[wr_ptr]    <= in_op.i_opcode;
      opa_mem[wr_ptr]    <= in_op.opa;
      opb_mem[wr_ptr]    <= in_op.opb;
      dest_mem[wr_ptr]   <= in_op.dest;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither keeps the level
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/alu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_control import mips_isa_pkg::*, alu_pkg::*; (
  input  alu_op_e    alu_op,     // Class from main control
  input  logic [5:0] func_code,  // R-type funct
  input  logic [5:0] i_opcode,   // I-type opcode
  output alu_ctrl_e  alu_ctrl
);

  always_comb begin
    alu_ctrl = ALU_ADD;  // Fallback for everything unlisted
    case (alu_op)
      ALU_OP_SUB: alu_ctrl = ALU_SUB;  // Branch compare
      ALU_OP_LUI: alu_ctrl = ALU_LUI;
      ALU_OP_RTYPE: begin
        case (func_code)
          FUNC_ADD,  FUNC_ADDU: alu_ctrl = ALU_ADD;  // Overflow ignored
          FUNC_SUB,  FUNC_SUBU: alu_ctrl = ALU_SUB;
          FUNC_AND:             alu_ctrl = ALU_AND;
          FUNC_OR:              alu_ctrl = ALU_OR;
          FUNC_NOR:             alu_ctrl = ALU_NOR;
          FUNC_XOR:             alu_ctrl = ALU_XOR;
          FUNC_SLT:             alu_ctrl = ALU_SLT;
          FUNC_SLTU:            alu_ctrl = ALU_SLTU;
          FUNC_SLL,  FUNC_SLLV: alu_ctrl = ALU_SLL;  // Count source chosen upstream
          FUNC_SRL,  FUNC_SRLV: alu_ctrl = ALU_SRL;
          FUNC_SRA,  FUNC_SRAV: alu_ctrl = ALU_SRA;
          default:              alu_ctrl = ALU_ADD;
        endcase
      end
      ALU_OP_IMM: begin
        // Immediate forms carry no funct, so the opcode picks the operation
        case (i_opcode)
          OPC_ANDI:  alu_ctrl = ALU_AND;
          OPC_ORI:   alu_ctrl = ALU_OR;
          OPC_XORI:  alu_ctrl = ALU_XOR;
          OPC_SLTI:  alu_ctrl = ALU_SLT;
          OPC_SLTIU: alu_ctrl = ALU_SLTU;  // Unsigned compare of sign-extended imm
          default:   alu_ctrl = ALU_ADD;
        endcase
      end
      default: alu_ctrl = ALU_ADD;  // ALU_OP_ADD
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage import alu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  ex_op_if.sink       in_op,
  output logic        res_valid,
  input  logic        res_ready,
  output logic [31:0] res_data,
  output logic [4:0]  res_dest
);

  alu_ctrl_e   alu_ctrl;  // Decoded operation
  logic [31:0] alu_res;
  logic [4:0]  shamt;     // Low bits of opa only
  logic        take;

  alu_control u_alu_control (
    .alu_op    (in_op.alu_op),
    .func_code (in_op.func_code),
    .i_opcode  (in_op.i_opcode),
    .alu_ctrl  (alu_ctrl)
  );

  assign shamt = in_op.opa[4:0];

  always_comb begin
    case (alu_ctrl)
      ALU_ADD:  alu_res = in_op.opa + in_op.opb;
      ALU_SUB:  alu_res = in_op.opa - in_op.opb;
      ALU_AND:  alu_res = in_op.opa & in_op.opb;
      ALU_OR:   alu_res = in_op.opa | in_op.opb;
      ALU_NOR:  alu_res = ~(in_op.opa | in_op.opb);
      ALU_XOR:  alu_res = in_op.opa ^ in_op.opb;
      ALU_SLT:  alu_res = {31'd0, $signed(in_op.opa) < $signed(in_op.opb)};
      ALU_SLTU: alu_res = {31'd0, in_op.opa < in_op.opb};
      ALU_SLL:  alu_res = in_op.opb << shamt;
      ALU_SRL:  alu_res = in_op.opb >> shamt;
      ALU_SRA:  alu_res = $signed(in_op.opb) >>> shamt;  // Sign fill
      ALU_LUI:  alu_res = {in_op.opb[15:0], 16'h0000};
      default:  alu_res = in_op.opa + in_op.opb;
    endcase
  end

  assign in_op.ready = !res_valid || res_ready;  // Empty or being drained
  assign take        = in_op.valid && in_op.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else if (in_op.ready) begin
      res_valid <= in_op.valid;
    end
  end

  // Result held until the consumer takes it
  always_ff @(posedge clk) begin
    if (take) begin
      res_data <= alu_res;
      res_dest <= in_op.dest;
    end
  end

endmodule

`default_nettype wire

/* hdl/mips_ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_ex_top #(
  parameter int FIFO_DEPTH = 4  // Power of two, at least 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid,
  output logic        instr_ready,
  input  logic [31:0] instr,
  input  logic [31:0] rs_val,
  input  logic [31:0] rt_val,
  output logic        res_valid,
  input  logic        res_ready,
  output logic [31:0] res_data,
  output logic [4:0]  res_dest
);

  ex_op_if dec_if ();   // Decoder to FIFO
  ex_op_if fifo_if ();  // FIFO to execute

  main_decoder u_main_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr       (instr),  // Raw word into the union view
    .rs_val      (rs_val),
    .rt_val      (rt_val),
    .out_op      (dec_if.source)
  );

  op_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_op_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .in_op  (dec_if.sink),
    .out_op (fifo_if.source)
  );

  ex_stage u_ex_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_op     (fifo_if.sink),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data),
    .res_dest  (res_dest)
  );

endmodule

`default_nettype wire

/* dv/mips_ex_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_ex_assert (
  input logic        clk,
  input logic        rst_n,
  input logic        instr_ready,
  input logic        res_valid,
  input logic        res_ready,
  input logic [31:0] res_data,
  input logic [4:0]  res_dest
);

  // Stalled result stays put until taken
  property p_res_hold;
    @(posedge clk) disable iff (!rst_n)
      res_valid && !res_ready |=> res_valid && $stable(res_data) && $stable(res_dest);
  endproperty

  a_res_hold: assert property (p_res_hold)
    else $error("res_valid or result changed while res_ready was low");

  a_reset_state: assert property (@(posedge clk) $rose(rst_n) |-> !res_valid && instr_ready)
    else $error("wrong handshake state in the first cycle after reset");

  a_res_known: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid |-> !$isunknown(res_data))
    else $error("res_data has unknown bits while res_valid is high");

endmodule

bind mips_ex_top mips_ex_assert u_mips_ex_assert (
  .clk(clk), .rst_n(rst_n), .instr_ready(instr_ready), .res_valid(res_valid),
  .res_ready(res_ready), .res_data(res_data), .res_dest(res_dest)
);

`default_nettype wire

/* dv/tb_mips_ex.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_ex import mips_isa_pkg::*;;

  localparam int FIFO_DEPTH = 4;
  localparam int ITER       = 4;               // Random repeats per instruction kind
  localparam int BURST      = FIFO_DEPTH + 6;  // More than can be in flight
  localparam int N_INSTR    = 1 + 16 * ITER + 8 * ITER + 5 * ITER + BURST;
  localparam int WATCHDOG_CYCLES = 20 * N_INSTR + 200;  // Generous even with stalls

  localparam logic [5:0] R_FUNCS [16] = '{FUNC_SLL, FUNC_SRL, FUNC_SRA, FUNC_SLLV, FUNC_SRLV,
    FUNC_SRAV, FUNC_ADD, FUNC_ADDU, FUNC_SUB, FUNC_SUBU, FUNC_AND, FUNC_OR, FUNC_XOR,
    FUNC_NOR, FUNC_SLT, FUNC_SLTU};
  localparam logic [5:0] I_OPCS [8] = '{OPC_ADDI, OPC_ADDIU, OPC_ANDI, OPC_ORI, OPC_XORI,
    OPC_SLTI, OPC_SLTIU, OPC_LUI};
  // Branches first, then opcodes the decoder does not know (LW, SW, J)
  localparam logic [5:0] OTHER_OPCS [5] = '{OPC_BEQ, OPC_BNE, 6'h23, 6'h2b, 6'h02};

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic        instr_ready;
  logic [31:0] instr;
  logic [31:0] rs_val;
  logic [31:0] rt_val;
  logic        res_valid;
  logic        res_ready;
  logic [31:0] res_data;
  logic [4:0]  res_dest;

  integer      seed = 32'h1ca9918f;
  int          errors;
  int          checks;
  logic [31:0] exp_data_q [$];  // Expected results in issue order
  logic [4:0]  exp_dest_q [$];
  logic        hold_res;        // Keep res_ready low
  logic        stall_mode;      // Random res_ready stalls

  mips_ex_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut (
    .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr_ready(instr_ready),
    .instr(instr), .rs_val(rs_val), .rt_val(rt_val), .res_valid(res_valid),
    .res_ready(res_ready), .res_data(res_data), .res_dest(res_dest)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Expected result straight from the ISA rules
  function automatic logic [31:0] model_result(input logic [31:0] w, input logic [31:0] a,
                                               input logic [31:0] b);
    logic [31:0] sext;
    logic [31:0] zext;
    logic [31:0] r;
    sext = {{16{w[15]}}, w[15:0]};
    zext = {16'h0000, w[15:0]};
    r    = a + sext;  // Unknown opcodes add
    case (w[31:26])
      OPC_RTYPE: begin
        case (w[5:0])
          FUNC_SLL:             r = b << w[10:6];
          FUNC_SRL:             r = b >> w[10:6];
          FUNC_SRA:             r = $signed(b) >>> w[10:6];
          FUNC_SLLV:            r = b << a[4:0];
          FUNC_SRLV:            r = b >> a[4:0];
          FUNC_SRAV:            r = $signed(b) >>> a[4:0];
          FUNC_SUB, FUNC_SUBU:  r = a - b;
          FUNC_AND:             r = a & b;
          FUNC_OR:              r = a | b;
          FUNC_XOR:             r = a ^ b;
          FUNC_NOR:             r = ~(a | b);
          FUNC_SLT:             r = {31'd0, $signed(a) < $signed(b)};
          FUNC_SLTU:            r = {31'd0, a < b};
          default:              r = a + b;
        endcase
      end
      OPC_ANDI:          r = a & zext;
      OPC_ORI:           r = a | zext;
      OPC_XORI:          r = a ^ zext;
      OPC_SLTI:          r = {31'd0, $signed(a) < $signed(sext)};
      OPC_SLTIU:         r = {31'd0, a < sext};  // Sign-extended, compared unsigned
      OPC_LUI:           r = {w[15:0], 16'h0000};
      OPC_BEQ, OPC_BNE:  r = a - b;
      default: ;
    endcase
    return r;
  endfunction

  function automatic logic [4:0] model_dest(input logic [31:0] w);
    case (w[31:26])
      OPC_RTYPE:        return w[15:11];  // rd
      OPC_BEQ, OPC_BNE: return 5'd0;
      default:          return w[20:16];  // rt
    endcase
  endfunction

  // Register fields come from random bits
  function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [31:0] rnd);
    return {OPC_RTYPE, rnd[25:6], fn};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] opc, input logic [31:0] rnd,
                                        input logic [15:0] imm);
    return {opc, rnd[25:16], imm};
  endfunction

  // Entered and left 1 ns after a rising edge
  task automatic push_instr(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b);
    exp_data_q.push_back(model_result(w, a, b));
    exp_dest_q.push_back(model_dest(w));
    instr       = w;
    rs_val      = a;
    rt_val      = b;
    instr_valid = 1'b1;
    while (!instr_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);  // Accepted here
    #1;
    instr_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_data_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);  // Last compared result leaves here
    #1;
  endtask

  task automatic test_reset_latency();
    logic [31:0] w;
    int cycles;
    check_value("res_valid", {31'd0, res_valid}, 32'd0);
    check_value("instr_ready", {31'd0, instr_ready}, 32'd1);
    w = enc_r(FUNC_ADD, $random(seed));
    exp_data_q.push_back(model_result(w, 32'h1234_5678, 32'h0fed_cba9));
    exp_dest_q.push_back(model_dest(w));
    instr       = w;
    rs_val      = 32'h1234_5678;
    rt_val      = 32'h0fed_cba9;
    instr_valid = 1'b1;
    cycles      = 0;
    // Counted from the cycle the word is presented
    do begin
      @(posedge clk);
      #1;
      cycles++;
      instr_valid = 1'b0;
    end while (!res_valid && cycles < 10);
    check_value("latency", cycles, 32'd3);
    wait_drain();
  endtask

  task automatic test_rtype();
    logic [31:0] b;
    for (int i = 0; i < 16; i++) begin
      for (int k = 0; k < ITER; k++) begin
        b = $random(seed);
        if (k == 0) b[31] = 1'b1;  // Negative rt for SRA sign fill and the compares
        push_instr(enc_r(R_FUNCS[i], $random(seed)), $random(seed), b);
      end
    end
    wait_drain();
  endtask

  task automatic test_itype();
    logic [31:0] rnd;
    logic [31:0] a;
    for (int i = 0; i < 8; i++) begin
      for (int k = 0; k < ITER; k++) begin
        rnd = $random(seed);
        if (k[0]) rnd[15] = 1'b1;  // Immediate with top bit set
        a = $random(seed);
        if (k == 3) a = {{16{rnd[15]}}, rnd[15:0]} - 32'd1;  // Just below the immediate
        push_instr(enc_i(I_OPCS[i], $random(seed), rnd[15:0]), a, $random(seed));
      end
    end
    wait_drain();
  endtask

  task automatic test_branch_other();
    logic [31:0] rnd;
    logic [31:0] a;
    for (int i = 0; i < 5; i++) begin
      for (int k = 0; k < ITER; k++) begin
        rnd = $random(seed);
        a   = $random(seed);
        push_instr(enc_i(OTHER_OPCS[i], $random(seed), rnd[15:0]), a,
                   (k == 0) ? a : rnd);  // Equal operands once
      end
    end
    wait_drain();
  endtask

  task automatic test_backpressure();
    hold_res = 1'b1;
    fork
      begin
        logic [31:0] rnd;
        for (int i = 0; i < BURST; i++) begin
          rnd = $random(seed);
          push_instr(enc_r(i[0] ? FUNC_SLT : FUNC_SUBU, rnd), $random(seed), rnd);
        end
      end
      begin
        int waited;
        waited = 0;
        while (instr_ready && waited < 10 * BURST) begin
          @(posedge clk);
          #1;
          waited++;
        end
        if (instr_ready) begin
          errors++;
          $display("instr_ready never dropped while res_ready was held low");
        end
        repeat (4) @(posedge clk);
        #1;
        check_value("instr_ready", {31'd0, instr_ready}, 32'd0);
        check_value("res_valid", {31'd0, res_valid}, 32'd1);
        // One queued entry is still waiting at the input
        check_value("ops_in_flight", exp_data_q.size() - 1, FIFO_DEPTH + 2);
        stall_mode = 1'b1;
        hold_res   = 1'b0;
      end
    join
    wait_drain();
    stall_mode = 1'b0;
  endtask

  // Every result transfer compared in order
  initial begin
    res_ready = 1'b0;
    wait (rst_n);
    forever begin
      @(posedge clk);
      #1;
      if (hold_res) res_ready = 1'b0;
      else if (stall_mode) res_ready = (($random(seed) & 3) != 0);
      else res_ready = 1'b1;
      if (res_valid && res_ready) begin
        if (exp_data_q.size() == 0) begin
          errors++;
          $display("Result %h came out with no instruction outstanding", res_data);
        end else begin
          check_value("res_data", res_data, exp_data_q.pop_front());
          check_value("res_dest", {27'd0, res_dest}, {27'd0, exp_dest_q.pop_front()});
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    instr_valid = 1'b0;
    instr       = '0;
    rs_val      = '0;
    rt_val      = '0;
    rst_n       = 1'b0;
    hold_res    = 1'b0;
    stall_mode  = 1'b0;
    errors      = 0;
    checks      = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_latency();
    test_rtype();
    test_itype();
    test_branch_other();
    test_backpressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
hdl/mips_isa_pkg.sv
hdl/alu_pkg.sv
hdl/ex_op_if.sv
hdl/main_decoder.sv
hdl/op_fifo.sv
hdl/alu_control.sv
hdl/ex_stage.sv
hdl/mips_ex_top.sv
dv/mips_ex_assert.sv
dv/tb_mips_ex.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert -Wno-fatal --top-module tb_mips_ex -f flist.f -Mdir obj_dir -o sim_tb
	@out=$$(./obj_dir/sim_tb); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
